// ==== hdl/irq_pkg.sv ====
// ##########################################################################
// widths, interrupt ids and vector types shared by the interrupt controller
// ##########################################################################

package irq_pkg;

  // core interrupt vector and id
  localparam int unsigned IRQ_W    = 32;
  localparam int unsigned IRQ_ID_W = 5;

  // level interrupt ids, as in the core's mip layout
  localparam int unsigned IRQ_ID_SW    = 3;
  localparam int unsigned IRQ_ID_TIMER = 7;
  localparam int unsigned IRQ_ID_EXT   = 11;

  // software, timer 0 and external
  localparam int unsigned LVL_IRQ_NUM = 3;

  // fast interrupts start at id 16, ids 30 and 31 stay unused
  localparam int unsigned FAST_IRQ_NUM  = 14;
  localparam int unsigned FAST_IRQ_BASE = 16;

  // source line counts
  localparam int unsigned TIMER_NUM   = 4;
  localparam int unsigned GPIO_AO_NUM = 8;

  typedef logic [IRQ_W-1:0]    irq_vec_t;
  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  // fast bit k is id 16+k
  //   [2:0]  timer 1..3
  //   [3]    dma done
  //   [4]    spi
  //   [5]    spi flash
  //   [13:6] gpio ao 0..7
  typedef logic [FAST_IRQ_NUM-1:0] fast_irq_t;

endpackage

// ==== hdl/irq_src_if.sv ====
// ##########################################################################
// synchronised interrupt sources, sync stage to pending stage
// ##########################################################################

`timescale 1ns/1ns

interface irq_src_if
  import irq_pkg::*;
();

  // one-cycle pulse per fast source on a rising edge
  fast_irq_t fast_rise;

  // synchronised levels
  logic      sw_lvl;
  logic      timer_lvl;
  logic      ext_lvl;

  modport sync (
    output fast_rise, sw_lvl, timer_lvl, ext_lvl
  );

  modport pend (
    input  fast_rise, sw_lvl, timer_lvl, ext_lvl
  );

endinterface

// ==== hdl/irq_sync_stage.sv ====
// ##########################################################################
// source synchroniser and rising edge detect for the fast interrupts
// ##########################################################################

`timescale 1ns/1ns

module irq_sync_stage
  import irq_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [TIMER_NUM-1:0]   timer_intr_i,
  input  logic                   dma_done_intr_i,
  input  logic                   spi_intr_i,
  input  logic                   spi_flash_intr_i,
  input  logic [GPIO_AO_NUM-1:0] gpio_ao_intr_i,
  input  logic                   irq_software_i,
  input  logic                   irq_external_i,
  irq_src_if.sync                src
);

  fast_irq_t              fast_raw;
  fast_irq_t              fast_s1;
  fast_irq_t              fast_s2;
  fast_irq_t              fast_s3;
  fast_irq_t              fast_rise_q;
  logic [LVL_IRQ_NUM-1:0] lvl_raw;
  logic [LVL_IRQ_NUM-1:0] lvl_s1;
  logic [LVL_IRQ_NUM-1:0] lvl_s2;
  logic [LVL_IRQ_NUM-1:0] lvl_q;

  // same packing as the mcu fast interrupt bus
  assign fast_raw = {
    gpio_ao_intr_i,
    spi_flash_intr_i,
    spi_intr_i,
    dma_done_intr_i,
    timer_intr_i[TIMER_NUM-1:1]
  };

  // timer 0 goes to the level path
  assign lvl_raw = {irq_external_i, timer_intr_i[0], irq_software_i};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fast_s1     <= '0;
      fast_s2     <= '0;
      fast_s3     <= '0;
      fast_rise_q <= '0;
      lvl_s1      <= '0;
      lvl_s2      <= '0;
      lvl_q       <= '0;
    end else begin
      fast_s1     <= fast_raw;
      fast_s2     <= fast_s1;
      fast_s3     <= fast_s2;
      // registered so levels and rise pulses leave together
      fast_rise_q <= fast_s2 & ~fast_s3;
      lvl_s1      <= lvl_raw;
      lvl_s2      <= lvl_s1;
      lvl_q       <= lvl_s2;
    end
  end

  assign src.fast_rise = fast_rise_q;
  assign src.sw_lvl    = lvl_q[0];
  assign src.timer_lvl = lvl_q[1];
  assign src.ext_lvl   = lvl_q[2];

  // a rise pulse only follows a low to high step of the synchronised line
  a_rise_from_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (fast_rise_q & ~($past(fast_s2) & ~$past(fast_s2, 2))) == '0);

endmodule

// ==== hdl/irq_pending_stage.sv ====
// ##########################################################################
// fast interrupt pending latches, acknowledge clear, 32-bit pending vector
// ##########################################################################

`timescale 1ns/1ns

module irq_pending_stage
  import irq_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  irq_src_if.pend  src,
  input  logic     irq_ack_i,
  input  irq_id_t  irq_ack_id_i,
  output irq_vec_t pending_o
);

  logic      ack_q;
  irq_id_t   ack_id_q;
  fast_irq_t fast_clr;
  fast_irq_t fast_pend;
  irq_vec_t  pending_d;
  irq_vec_t  pending_q;

  // ack registered so the clear lands one edge later
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q    <= 1'b0;
      ack_id_q <= '0;
    end else begin
      ack_q    <= irq_ack_i;
      ack_id_q <= irq_ack_id_i;
    end
  end

  // only ids 16..29 map to a latch
  always_comb begin
    fast_clr = '0;
    for (int k = 0; k < FAST_IRQ_NUM; k++) begin
      if (ack_q && (ack_id_q == irq_id_t'(FAST_IRQ_BASE + k))) begin
        fast_clr[k] = 1'b1;
      end
    end
  end

  assign fast_pend = pending_q[FAST_IRQ_BASE +: FAST_IRQ_NUM];

  always_comb begin
    pending_d               = '0;
    pending_d[IRQ_ID_SW]    = src.sw_lvl;
    pending_d[IRQ_ID_TIMER] = src.timer_lvl;
    pending_d[IRQ_ID_EXT]   = src.ext_lvl;
    // set beats clear when both hit the same bit
    pending_d[FAST_IRQ_BASE +: FAST_IRQ_NUM] = src.fast_rise | (fast_pend & ~fast_clr);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  assign pending_o = pending_q;

  a_ack_id_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_ack_i |-> !$isunknown(irq_ack_id_i));

endmodule

// ==== hdl/irq_priority_stage.sv ====
// ##########################################################################
// enable mask, fixed priority select, registered request and id
// ##########################################################################

`timescale 1ns/1ns

module irq_priority_stage
  import irq_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  irq_vec_t pending_i,
  input  irq_vec_t irq_enable_i,
  output logic     irq_o,
  output irq_id_t  irq_id_o
);

  irq_vec_t masked;
  logic     irq_d;
  irq_id_t  id_d;
  logic     irq_q;
  irq_id_t  id_q;

  assign masked = pending_i & irq_enable_i;

  always_comb begin
    irq_d = 1'b0;
    id_d  = '0;
    // highest fast id wins, so scan upward and keep the last hit
    for (int k = 0; k < FAST_IRQ_NUM; k++) begin
      if (masked[FAST_IRQ_BASE + k]) begin
        irq_d = 1'b1;
        id_d  = irq_id_t'(FAST_IRQ_BASE + k);
      end
    end
    // then external, software, timer
    if (!irq_d) begin
      if (masked[IRQ_ID_EXT]) begin
        irq_d = 1'b1;
        id_d  = irq_id_t'(IRQ_ID_EXT);
      end else if (masked[IRQ_ID_SW]) begin
        irq_d = 1'b1;
        id_d  = irq_id_t'(IRQ_ID_SW);
      end else if (masked[IRQ_ID_TIMER]) begin
        irq_d = 1'b1;
        id_d  = irq_id_t'(IRQ_ID_TIMER);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      irq_q <= 1'b0;
      id_q  <= '0;
    end else begin
      irq_q <= irq_d;
      id_q  <= id_d;
    end
  end

  assign irq_o    = irq_q;
  assign irq_id_o = id_q;

  a_id_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_q |-> ((id_q inside {IRQ_ID_SW, IRQ_ID_TIMER, IRQ_ID_EXT}) ||
               ((id_q >= FAST_IRQ_BASE) && (id_q < FAST_IRQ_BASE + FAST_IRQ_NUM))));

  a_idle_id_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !irq_q |-> (id_q == '0));

endmodule

// ==== hdl/mcu_irq_ctrl.sv ====
// ##########################################################################
// interrupt controller top, sync, pending and priority stages in a row
// ##########################################################################

`timescale 1ns/1ns

module mcu_irq_ctrl
  import irq_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // interrupt sources
  input  logic [TIMER_NUM-1:0]   timer_intr_i,
  input  logic                   dma_done_intr_i,
  input  logic                   spi_intr_i,
  input  logic                   spi_flash_intr_i,
  input  logic [GPIO_AO_NUM-1:0] gpio_ao_intr_i,
  input  logic                   irq_software_i,
  input  logic                   irq_external_i,

  // core side
  input  logic [IRQ_W-1:0]       irq_enable_i,
  input  logic                   irq_ack_i,
  input  logic [IRQ_ID_W-1:0]    irq_ack_id_i,
  output logic                   irq_o,
  output logic [IRQ_ID_W-1:0]    irq_id_o,
  output logic [IRQ_W-1:0]       irq_pending_o
);

  irq_src_if src_if ();

  irq_sync_stage u_sync (
    .clk_i,
    .rst_n_i,
    .timer_intr_i,
    .dma_done_intr_i,
    .spi_intr_i,
    .spi_flash_intr_i,
    .gpio_ao_intr_i,
    .irq_software_i,
    .irq_external_i,
    .src              (src_if.sync)
  );

  irq_pending_stage u_pending (
    .clk_i,
    .rst_n_i,
    .src          (src_if.pend),
    .irq_ack_i,
    .irq_ack_id_i,
    .pending_o    (irq_pending_o)
  );

  // pending vector also goes straight out to the core
  irq_priority_stage u_priority (
    .clk_i,
    .rst_n_i,
    .pending_i    (irq_pending_o),
    .irq_enable_i,
    .irq_o,
    .irq_id_o
  );

endmodule

// ==== bench/irq_ref_model.svh ====
// ##########################################################################
// reference model of the fast latches, pending vector and priority rule
// ##########################################################################

`ifndef IRQ_REF_MODEL_SVH
`define IRQ_REF_MODEL_SVH

fast_irq_t m_fast;
logic      m_sw;
logic      m_timer;
logic      m_ext;

function automatic void model_reset();
  m_fast  = '0;
  m_sw    = 1'b0;
  m_timer = 1'b0;
  m_ext   = 1'b0;
endfunction

// a rising fast source latches its bit
function automatic void model_rise(input fast_irq_t rise);
  m_fast = m_fast | rise;
endfunction

// only ids 16..29 own a latch
function automatic void model_ack(input irq_id_t id);
  int unsigned idx;
  idx = 32'(id);
  if ((idx >= FAST_IRQ_BASE) && (idx < FAST_IRQ_BASE + FAST_IRQ_NUM)) begin
    m_fast[idx - FAST_IRQ_BASE] = 1'b0;
  end
endfunction

function automatic irq_vec_t model_pending();
  irq_vec_t v;
  v                                = '0;
  v[IRQ_ID_SW]                     = m_sw;
  v[IRQ_ID_TIMER]                  = m_timer;
  v[IRQ_ID_EXT]                    = m_ext;
  v[FAST_IRQ_BASE +: FAST_IRQ_NUM] = m_fast;
  return v;
endfunction

function automatic logic model_irq(input irq_vec_t pend, input irq_vec_t en);
  return |(pend & en);
endfunction

// highest fast id first, then external, software, timer
function automatic irq_id_t model_winner(input irq_vec_t pend, input irq_vec_t en);
  irq_vec_t m;
  m = pend & en;
  for (int id = FAST_IRQ_BASE + FAST_IRQ_NUM - 1; id >= int'(FAST_IRQ_BASE); id--) begin
    if (m[id]) return irq_id_t'(id);
  end
  if (m[IRQ_ID_EXT]) return irq_id_t'(IRQ_ID_EXT);
  if (m[IRQ_ID_SW]) return irq_id_t'(IRQ_ID_SW);
  if (m[IRQ_ID_TIMER]) return irq_id_t'(IRQ_ID_TIMER);
  return '0;
endfunction

`endif

// ==== bench/tb_mcu_irq_ctrl.sv ====
// ##########################################################################
// testbench for the interrupt controller with random stimulus and a model
// ##########################################################################

`timescale 1ns/1ns

module tb_mcu_irq_ctrl
  import irq_pkg::*;
();

  localparam int CLK_PERIOD  = 4;
  localparam int RESET_CYC   = 10;
  localparam int SETTLE_CYC  = 6;
  localparam int LVL_ROUNDS  = 16;
  localparam int FAST_ROUNDS = 16;
  localparam int ACK_ROUNDS  = 32;
  localparam int PRIO_ROUNDS = 64;
  localparam int EDGE_ROUNDS = 8;
  // generous bound on the cycles of a single round
  localparam int ROUND_CYC   = 40;
  localparam int TOTAL_CYC   = RESET_CYC + ROUND_CYC *
    (LVL_ROUNDS + FAST_ROUNDS + ACK_ROUNDS + 8 + PRIO_ROUNDS + 2 * EDGE_ROUNDS);
  localparam int TIMEOUT_NS  = (TOTAL_CYC + 500) * CLK_PERIOD;

  localparam irq_id_t NO_LATCH_IDS [6] = '{5'd0, 5'd3, 5'd7, 5'd11, 5'd30, 5'd31};

  logic                   clk;
  logic                   rst_n;
  logic [TIMER_NUM-1:0]   timer_intr;
  logic                   dma_done_intr;
  logic                   spi_intr;
  logic                   spi_flash_intr;
  logic [GPIO_AO_NUM-1:0] gpio_ao_intr;
  logic                   irq_software;
  logic                   irq_external;
  irq_vec_t               irq_enable;
  logic                   irq_ack;
  irq_id_t                irq_ack_id;
  logic                   irq;
  irq_id_t                irq_id;
  irq_vec_t               irq_pending;
  integer                 seed;

  `include "irq_ref_model.svh"

  mcu_irq_ctrl u_dut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .timer_intr_i     (timer_intr),
    .dma_done_intr_i  (dma_done_intr),
    .spi_intr_i       (spi_intr),
    .spi_flash_intr_i (spi_flash_intr),
    .gpio_ao_intr_i   (gpio_ao_intr),
    .irq_software_i   (irq_software),
    .irq_external_i   (irq_external),
    .irq_enable_i     (irq_enable),
    .irq_ack_i        (irq_ack),
    .irq_ack_id_i     (irq_ack_id),
    .irq_o            (irq),
    .irq_id_o         (irq_id),
    .irq_pending_o    (irq_pending)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %08h actual %08h", name, expected, actual);
      $display("Done: errors found");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic check_outputs(input string name);
    irq_vec_t pend;
    pend = model_pending();
    check_value({name, "_pending"}, pend, irq_pending);
    check_value({name, "_irq"}, 32'(model_irq(pend, irq_enable)), 32'(irq));
    check_value({name, "_id"}, 32'(model_winner(pend, irq_enable)), 32'(irq_id));
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    int unsigned r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic logic rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  // fast bit order is timer 1..3, dma, spi, spi flash, gpio 0..7
  task automatic drive_fast(input fast_irq_t v);
    timer_intr[TIMER_NUM-1:1] = v[2:0];
    dma_done_intr             = v[3];
    spi_intr                  = v[4];
    spi_flash_intr            = v[5];
    gpio_ao_intr              = v[13:6];
  endtask

  task automatic pulse_fast(input fast_irq_t v, input int cycles);
    drive_fast(v);
    wait_cycles(cycles);
    drive_fast('0);
    model_rise(v);
  endtask

  task automatic drive_levels(input logic sw, input logic tmr, input logic ext);
    irq_software  = sw;
    timer_intr[0] = tmr;
    irq_external  = ext;
    m_sw          = sw;
    m_timer       = tmr;
    m_ext         = ext;
  endtask

  task automatic send_ack(input irq_id_t id);
    irq_ack    = 1'b1;
    irq_ack_id = id;
    wait_cycles(1);
    irq_ack    = 1'b0;
    irq_ack_id = '0;
    model_ack(id);
  endtask

  initial begin
    int unsigned bit_k;
    int unsigned n_ack;
    irq_id_t     old_id;
    irq_id_t     new_id;
    fast_irq_t   fast_set;
    seed         = 32'hf338_c407;
    rst_n        = 1'b0;
    timer_intr   = '0;
    drive_fast('0);
    irq_software = 1'b0;
    irq_external = 1'b0;
    irq_ack      = 1'b0;
    irq_ack_id   = '0;
    irq_enable   = $random(seed);
    model_reset();

    wait_cycles(RESET_CYC / 2);
    check_outputs("reset_hold");
    wait_cycles(RESET_CYC - RESET_CYC / 2);
    rst_n = 1'b1;
    check_outputs("reset_exit");
    wait_cycles(SETTLE_CYC);
    check_outputs("reset_idle");

    for (int i = 0; i < LVL_ROUNDS; i++) begin
      irq_enable = $random(seed);
      drive_levels(rand_bit(), rand_bit(), rand_bit());
      wait_cycles(SETTLE_CYC);
      check_outputs("level_set");
      drive_levels(1'b0, 1'b0, 1'b0);
      wait_cycles(SETTLE_CYC);
      check_outputs("level_clear");
    end

    for (int i = 0; i < FAST_ROUNDS; i++) begin
      // empty the latches now and then so new bits stay visible
      if (i % 4 == 0) begin
        for (int k = 0; k < FAST_IRQ_NUM; k++) begin
          send_ack(irq_id_t'(FAST_IRQ_BASE + k));
        end
        wait_cycles(SETTLE_CYC);
      end
      fast_set = fast_irq_t'($random(seed) & $random(seed));
      pulse_fast(fast_set, 1 + int'(rand_below(3)));
      wait_cycles(SETTLE_CYC);
      check_outputs("fast_latch");
    end

    for (int i = 0; i < ACK_ROUNDS; i++) begin
      if (i % 4 == 0) begin
        pulse_fast(fast_irq_t'($random(seed)), 1);
        wait_cycles(SETTLE_CYC);
      end
      send_ack(irq_id_t'($random(seed)));
      wait_cycles(SETTLE_CYC);
      check_outputs("ack_random");
    end

    // ids without a latch leave the vector alone
    drive_levels(1'b1, 1'b1, 1'b1);
    pulse_fast('1, 1);
    wait_cycles(SETTLE_CYC);
    foreach (NO_LATCH_IDS[n]) begin
      send_ack(NO_LATCH_IDS[n]);
      wait_cycles(SETTLE_CYC);
      check_outputs("ack_no_latch");
    end

    for (int i = 0; i < PRIO_ROUNDS; i++) begin
      drive_levels(rand_bit(), rand_bit(), rand_bit());
      fast_set = fast_irq_t'($random(seed) & $random(seed) & $random(seed));
      pulse_fast(fast_set, 1 + int'(rand_below(3)));
      wait_cycles(SETTLE_CYC);
      n_ack = rand_below(4);
      for (int j = 0; j < int'(n_ack); j++) begin
        send_ack(irq_id_t'(FAST_IRQ_BASE + rand_below(FAST_IRQ_NUM)));
      end
      irq_enable = (i % 8 == 0) ? '1 : $random(seed);
      wait_cycles(SETTLE_CYC);
      check_outputs("priority");
    end

    irq_enable = '1;
    for (int i = 0; i < EDGE_ROUNDS; i++) begin
      bit_k = rand_below(FAST_IRQ_NUM);
      pulse_fast(fast_irq_t'(1) << bit_k, 1);
      wait_cycles(SETTLE_CYC);
      // rise sampled at edge N and ack at N+2 reach the latch together
      drive_fast(fast_irq_t'(1) << bit_k);
      wait_cycles(1);
      drive_fast('0);
      wait_cycles(1);
      send_ack(irq_id_t'(FAST_IRQ_BASE + bit_k));
      model_rise(fast_irq_t'(1) << bit_k);
      wait_cycles(SETTLE_CYC);
      check_value("ack_vs_rise_bit", 32'd1, 32'(irq_pending[FAST_IRQ_BASE + bit_k]));
      check_outputs("ack_vs_rise");
    end

    for (int i = 0; i < EDGE_ROUNDS; i++) begin
      pulse_fast(fast_irq_t'($random(seed)) | fast_irq_t'(1), 1);
      wait_cycles(SETTLE_CYC);
      old_id = model_winner(model_pending(), irq_enable);
      send_ack(old_id);
      new_id = model_winner(model_pending(), irq_enable);
      check_value("ack_winner_m", 32'(old_id), 32'(irq_id));
      wait_cycles(1);
      check_value("ack_winner_m1", 32'(old_id), 32'(irq_id));
      wait_cycles(1);
      check_value("ack_winner_m2", 32'(new_id), 32'(irq_id));
      wait_cycles(SETTLE_CYC);
      check_outputs("ack_winner");
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+bench
hdl/irq_pkg.sv
hdl/irq_src_if.sv
hdl/irq_sync_stage.sv
hdl/irq_pending_stage.sv
hdl/irq_priority_stage.sv
hdl/mcu_irq_ctrl.sv
bench/tb_mcu_irq_ctrl.sv

// ==== Makefile ====
# verilator lint and simulation of the interrupt controller

VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= tb_mcu_irq_ctrl
RTL_TOP   ?= mcu_irq_ctrl
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
LINTFLAGS ?= --lint-only --timing
VFLAGS    ?= --timing --assert -Wno-fatal

SRCS    := $(shell grep -v '^+' $(FILELIST)) bench/irq_ref_model.svh
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q '^Done: no errors$$' $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
